//--- soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Word memory
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Instruction queue
    localparam int IQ_DEPTH = 4;
    localparam int IQ_CNT_W = 3;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);

    // Timer block
    localparam int FMAX_MHZ = 27;                   // Clock cycles per microsecond
    localparam int PRESC_W  = $clog2(FMAX_MHZ);
    localparam int TSEL_W   = 3;

    localparam addr_t TIMER_BASE = 32'h8000_0000;   // Bit 31 selects the timer window
    localparam addr_t RESET_PC   = 32'h0000_0000;

    // Timer register offsets, taken from address bits 4 to 2
    localparam logic [TSEL_W-1:0] TSEL_MTIME_LO = 3'd0;
    localparam logic [TSEL_W-1:0] TSEL_MTIME_HI = 3'd1;
    localparam logic [TSEL_W-1:0] TSEL_CMP_LO   = 3'd2;
    localparam logic [TSEL_W-1:0] TSEL_CMP_HI   = 3'd3;
    localparam logic [TSEL_W-1:0] TSEL_CYCLE_LO = 3'd4;

endpackage

//--- soc_timer.sv
module soc_timer
    import soc_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [TSEL_W-1:0] wr_sel,
    input  word_t             wr_data,
    input  logic [TSEL_W-1:0] rd_sel,
    output word_t             rd_data,
    output logic              timer_irq
);

    logic [63:0]        cycle;
    logic [63:0]        mtime;
    logic [63:0]        mtimecmp;
    logic [PRESC_W-1:0] presc;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            cycle    <= '0;
            mtime    <= '0;
            presc    <= '0;
            mtimecmp <= '1;                         // No interrupt until software sets it
        end else begin
            cycle <= cycle + 64'd1;
            if (presc == PRESC_W'(FMAX_MHZ - 1)) begin
                presc <= '0;
                mtime <= mtime + 64'd1;             // One tick per microsecond
            end else begin
                presc <= presc + 1'b1;
            end
            if (wr_en && wr_sel == TSEL_CMP_LO) mtimecmp[31:0]  <= wr_data;
            if (wr_en && wr_sel == TSEL_CMP_HI) mtimecmp[63:32] <= wr_data;
        end
    end

    always_ff @(posedge clk_in) begin
        case (rd_sel)
            TSEL_MTIME_LO: rd_data <= mtime[31:0];
            TSEL_MTIME_HI: rd_data <= mtime[63:32];
            TSEL_CMP_LO:   rd_data <= mtimecmp[31:0];
            TSEL_CMP_HI:   rd_data <= mtimecmp[63:32];
            TSEL_CYCLE_LO: rd_data <= cycle[31:0];
            default:       rd_data <= '0;
        endcase
    end

    assign timer_irq = (mtime >= mtimecmp);

    a_presc_range: assert property (@(posedge clk_in) disable iff (reset)
        presc < PRESC_W'(FMAX_MHZ));

endmodule

//--- soc_memory.sv
module soc_memory
    import soc_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  logic  req_wen,
    input  word_t req_wdata,
    output logic  req_ready,
    output logic  resp_valid,
    output word_t resp_rdata
);

    word_t                mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;
    logic                 xfer;

    assign req_ready = 1'b1;                        // Single-cycle array, never stalls
    assign xfer      = req_valid && req_ready;
    assign idx       = req_addr[MEM_IDX_W+1:2];

    always_ff @(posedge clk_in) begin
        if (xfer) begin
            if (req_wen) begin
                mem[idx] <= req_wdata;
            end
            resp_rdata <= mem[idx];                 // Old contents on a write, ignored
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= xfer;
        end
    end

    a_addr_range: assert property (@(posedge clk_in) disable iff (reset)
        xfer |-> req_addr < addr_t'(MEM_WORDS * 4));

endmodule

//--- mem_bus_cntr.sv
module mem_bus_cntr
    import soc_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    // Fetch port
    input  logic              fetch_req_valid,
    output logic              fetch_req_ready,
    input  addr_t             fetch_req_addr,
    output logic              fetch_resp_valid,
    output word_t             fetch_resp_rdata,
    // Data port
    input  logic              dreq_valid,
    output logic              dreq_ready,
    input  addr_t             dreq_addr,
    input  logic              dreq_wen,
    input  word_t             dreq_wdata,
    output logic              dresp_valid,
    output word_t             dresp_rdata,
    // Memory bus
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    output addr_t             mem_req_addr,
    output logic              mem_req_wen,
    output word_t             mem_req_wdata,
    input  logic              mem_resp_valid,
    input  word_t             mem_resp_rdata,
    // Timer registers
    output logic              tmr_wr_en,
    output logic [TSEL_W-1:0] tmr_wr_sel,
    output word_t             tmr_wr_data,
    output logic [TSEL_W-1:0] tmr_rd_sel,
    input  word_t             tmr_rd_data
);

    logic busy;                                     // One transaction in flight
    logic owner_d;                                  // In-flight access belongs to data port
    logic tgt_tmr;                                  // In-flight access targets the timer
    logic data_tmr;
    logic d_xfer;
    logic f_xfer;

    assign data_tmr = (dreq_addr & TIMER_BASE) != '0;

    assign dreq_ready      = !busy && (data_tmr || mem_req_ready);
    assign fetch_req_ready = !busy && !dreq_valid && mem_req_ready;   // Data goes first
    assign d_xfer          = dreq_valid && dreq_ready;
    assign f_xfer          = fetch_req_valid && fetch_req_ready;

    assign mem_req_valid = !busy && (dreq_valid ? !data_tmr : fetch_req_valid);
    assign mem_req_addr  = dreq_valid ? dreq_addr : fetch_req_addr;
    assign mem_req_wen   = dreq_valid && dreq_wen;
    assign mem_req_wdata = dreq_wdata;

    assign tmr_wr_en   = d_xfer && data_tmr && dreq_wen;
    assign tmr_wr_sel  = dreq_addr[4:2];
    assign tmr_wr_data = dreq_wdata;
    assign tmr_rd_sel  = dreq_addr[4:2];            // Timer registers its read on transfer

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
            tgt_tmr <= 1'b0;
        end else if (d_xfer || f_xfer) begin
            busy    <= 1'b1;
            owner_d <= d_xfer;
            tgt_tmr <= d_xfer && data_tmr;
        end else if (busy && (tgt_tmr || mem_resp_valid)) begin
            busy <= 1'b0;
        end
    end

    assign dresp_valid      = busy && owner_d && (tgt_tmr || mem_resp_valid);
    assign dresp_rdata      = tgt_tmr ? tmr_rd_data : mem_resp_rdata;
    assign fetch_resp_valid = busy && !owner_d && mem_resp_valid;
    assign fetch_resp_rdata = mem_resp_rdata;

    a_no_grant_busy: assert property (@(posedge clk_in) disable iff (reset)
        busy |-> !(d_xfer || f_xfer));

    a_resp_expected: assert property (@(posedge clk_in) disable iff (reset)
        mem_resp_valid |-> busy && !tgt_tmr);

endmodule

//--- inst_fetcher.sv
module inst_fetcher
    import soc_pkg::*;
(
    input  logic                clk_in,
    input  logic                reset,
    input  logic                redirect,
    input  addr_t               redirect_pc,
    input  logic [IQ_CNT_W-1:0] iq_count,
    output logic                fetch_req_valid,
    input  logic                fetch_req_ready,
    output addr_t               fetch_req_addr,
    input  logic                fetch_resp_valid,
    input  word_t               fetch_resp_rdata,
    output logic                iq_push,
    output addr_t               iq_push_pc,
    output word_t               iq_push_inst
);

    addr_t pc;                                      // Next address to request
    addr_t out_pc;                                  // Address of the request in flight
    logic  pending;
    logic  run;
    logic  room;
    logic  req_xfer;

    // Reserve a queue slot for the word still in flight
    assign room = (iq_count + IQ_CNT_W'(pending)) < IQ_CNT_W'(IQ_DEPTH);

    assign fetch_req_valid = run && !redirect && !pending && room;
    assign fetch_req_addr  = pc;
    assign req_xfer        = fetch_req_valid && fetch_req_ready;

    assign iq_push      = fetch_resp_valid && !redirect;   // Word landing with a redirect is dropped
    assign iq_push_pc   = out_pc;
    assign iq_push_inst = fetch_resp_rdata;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            run     <= 1'b0;
            pc      <= RESET_PC;
            pending <= 1'b0;
        end else begin
            run <= 1'b1;                            // Start fetching the cycle after reset
            if (redirect) begin
                pc <= redirect_pc;
            end else if (req_xfer) begin
                pc <= pc + 32'd4;
            end
            if (req_xfer) begin
                pending <= 1'b1;
            end else if (fetch_resp_valid) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_xfer) begin
            out_pc <= pc;
        end
    end

endmodule

//--- inst_queue.sv
module inst_queue
    import soc_pkg::*;
(
    input  logic                clk_in,
    input  logic                reset,
    input  logic                flush,
    input  logic                push,
    input  addr_t               push_pc,
    input  word_t               push_inst,
    output logic                pop_valid,
    input  logic                pop_ready,
    output addr_t               pop_pc,
    output word_t               pop_inst,
    output logic [IQ_CNT_W-1:0] count
);

    addr_t                pc_mem   [IQ_DEPTH];
    word_t                inst_mem [IQ_DEPTH];
    logic [IQ_PTR_W-1:0]  wr_ptr;
    logic [IQ_PTR_W-1:0]  rd_ptr;
    logic                 pop;

    assign pop_valid = (count != '0);
    assign pop       = pop_valid && pop_ready;
    assign pop_pc    = pc_mem[rd_ptr];
    assign pop_inst  = inst_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;      // Depth is a power of two, pointers wrap
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + IQ_CNT_W'(push) - IQ_CNT_W'(pop);
        end
    end

    a_no_overflow: assert property (@(posedge clk_in) disable iff (reset)
        push |-> count < IQ_CNT_W'(IQ_DEPTH));

endmodule

//--- soc_top.sv
module soc_top
    import soc_pkg::*;
(
    input  logic  clk_in,
    input  logic  reset,
    input  logic  dreq_valid,
    output logic  dreq_ready,
    input  addr_t dreq_addr,
    input  logic  dreq_wen,
    input  word_t dreq_wdata,
    output logic  dresp_valid,
    output word_t dresp_rdata,
    output logic  inst_valid,
    input  logic  inst_ready,
    output addr_t inst_pc,
    output word_t inst_data,
    input  logic  redirect,
    input  addr_t redirect_pc,
    output logic  timer_irq
);

    logic                mem_req_valid;
    logic                mem_req_ready;
    addr_t               mem_req_addr;
    logic                mem_req_wen;
    word_t               mem_req_wdata;
    logic                mem_resp_valid;
    word_t               mem_resp_rdata;

    logic                fetch_req_valid;
    logic                fetch_req_ready;
    addr_t               fetch_req_addr;
    logic                fetch_resp_valid;
    word_t               fetch_resp_rdata;

    logic                tmr_wr_en;
    logic [TSEL_W-1:0]   tmr_wr_sel;
    word_t               tmr_wr_data;
    logic [TSEL_W-1:0]   tmr_rd_sel;
    word_t               tmr_rd_data;

    logic                iq_push;
    addr_t               iq_push_pc;
    word_t               iq_push_inst;
    logic [IQ_CNT_W-1:0] iq_count;

    soc_timer i_soc_timer (
        .clk_in    (clk_in),
        .reset     (reset),
        .wr_en     (tmr_wr_en),
        .wr_sel    (tmr_wr_sel),
        .wr_data   (tmr_wr_data),
        .rd_sel    (tmr_rd_sel),
        .rd_data   (tmr_rd_data),
        .timer_irq (timer_irq)
    );

    soc_memory i_soc_memory (
        .clk_in     (clk_in),
        .reset      (reset),
        .req_valid  (mem_req_valid),
        .req_addr   (mem_req_addr),
        .req_wen    (mem_req_wen),
        .req_wdata  (mem_req_wdata),
        .req_ready  (mem_req_ready),
        .resp_valid (mem_resp_valid),
        .resp_rdata (mem_resp_rdata)
    );

    mem_bus_cntr i_mem_bus_cntr (
        .clk_in           (clk_in),
        .reset            (reset),
        .fetch_req_valid  (fetch_req_valid),
        .fetch_req_ready  (fetch_req_ready),
        .fetch_req_addr   (fetch_req_addr),
        .fetch_resp_valid (fetch_resp_valid),
        .fetch_resp_rdata (fetch_resp_rdata),
        .dreq_valid       (dreq_valid),
        .dreq_ready       (dreq_ready),
        .dreq_addr        (dreq_addr),
        .dreq_wen         (dreq_wen),
        .dreq_wdata       (dreq_wdata),
        .dresp_valid      (dresp_valid),
        .dresp_rdata      (dresp_rdata),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .mem_req_addr     (mem_req_addr),
        .mem_req_wen      (mem_req_wen),
        .mem_req_wdata    (mem_req_wdata),
        .mem_resp_valid   (mem_resp_valid),
        .mem_resp_rdata   (mem_resp_rdata),
        .tmr_wr_en        (tmr_wr_en),
        .tmr_wr_sel       (tmr_wr_sel),
        .tmr_wr_data      (tmr_wr_data),
        .tmr_rd_sel       (tmr_rd_sel),
        .tmr_rd_data      (tmr_rd_data)
    );

    inst_fetcher i_inst_fetcher (
        .clk_in           (clk_in),
        .reset            (reset),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .iq_count         (iq_count),
        .fetch_req_valid  (fetch_req_valid),
        .fetch_req_ready  (fetch_req_ready),
        .fetch_req_addr   (fetch_req_addr),
        .fetch_resp_valid (fetch_resp_valid),
        .fetch_resp_rdata (fetch_resp_rdata),
        .iq_push          (iq_push),
        .iq_push_pc       (iq_push_pc),
        .iq_push_inst     (iq_push_inst)
    );

    inst_queue i_inst_queue (
        .clk_in    (clk_in),
        .reset     (reset),
        .flush     (redirect),                      // Redirect empties the queue
        .push      (iq_push),
        .push_pc   (iq_push_pc),
        .push_inst (iq_push_inst),
        .pop_valid (inst_valid),
        .pop_ready (inst_ready),
        .pop_pc    (inst_pc),
        .pop_inst  (inst_data),
        .count     (iq_count)
    );

endmodule

//--- tb_soc_top.sv
module tb_soc_top
    import soc_pkg::*;
();

    localparam int RST_CYCLES = 8;
    localparam int NUM_READS  = 32;
    localparam int SEQ_POPS   = 64;
    localparam int REDIR_POPS = 16;
    localparam int BP_CYCLES  = 150;
    localparam int TMR_GAP    = 40;
    localparam int MAX_CYCLES = 4000;               // Roughly four times the sum of all phases

    logic  clk_in;
    logic  reset;
    logic  dreq_valid;
    logic  dreq_ready;
    addr_t dreq_addr;
    logic  dreq_wen;
    word_t dreq_wdata;
    logic  dresp_valid;
    word_t dresp_rdata;
    logic  inst_valid;
    logic  inst_ready;
    addr_t inst_pc;
    word_t inst_data;
    logic  redirect;
    addr_t redirect_pc;
    logic  timer_irq;

    word_t  shadow [MEM_WORDS];
    addr_t  read_addr [NUM_READS];
    integer seed;
    int     err_count;
    int     check_count;
    int     pop_count;
    int     cycle_cnt;
    int     pops_before;
    addr_t  exp_pc;
    logic   mon_en;
    word_t  rnd_word;
    word_t  rd_word;
    word_t  val_a;
    word_t  val_b;

    soc_top i_soc_top (.*);

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic word_t expected_inst(input addr_t pc);
        return shadow[pc[MEM_IDX_W+1:2]];
    endfunction

    function automatic addr_t timer_addr(input logic [TSEL_W-1:0] sel);
        return TIMER_BASE | addr_t'({sel, 2'b00});
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input addr_t exp, input addr_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Entered and left 1 unit after a rising edge
    task automatic data_access(input addr_t addr, input logic wen, input word_t wdata,
                               input logic want_resp, output word_t rdata);
        dreq_valid = 1'b1;
        dreq_addr  = addr;
        dreq_wen   = wen;
        dreq_wdata = wdata;
        @(negedge clk_in);
        while (!dreq_ready) @(negedge clk_in);
        @(posedge clk_in);
        #1 dreq_valid = 1'b0;
        rdata = '0;
        if (want_resp) begin
            @(negedge clk_in);
            if (dresp_valid !== 1'b1) begin
                err_count++;
                $display("Data port gave no response for address %h", addr);
            end
            rdata = dresp_rdata;
            @(posedge clk_in);
            #1;
        end
    endtask

    task automatic send_redirect(input addr_t pc);
        inst_ready  = 1'b0;                         // No pop in the flush cycle
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clk_in);
        #1 redirect = 1'b0;
    endtask

    task automatic wait_pops(input int n);
        int goal;
        goal = pop_count + n;
        while (pop_count < goal) @(posedge clk_in);
        #1;
    endtask

    // Compares every popped entry with the shadow memory
    always @(negedge clk_in) begin
        if (mon_en && redirect) begin
            exp_pc = redirect_pc;
        end else if (mon_en && inst_valid && inst_ready) begin
            check_pc("fetch_pc", exp_pc, inst_pc);
            check_word("fetch_inst", expected_inst(exp_pc), inst_data);
            exp_pc = exp_pc + 32'd4;
            pop_count++;
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_in);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks: %0d, errors: %0d, pops: %0d", check_count, err_count, pop_count);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_wen    = 1'b0;
        dreq_wdata  = '0;
        inst_ready  = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        mon_en      = 1'b0;
        exp_pc      = RESET_PC;
        seed        = 32'he0c6_d0b5;
        repeat (RST_CYCLES) @(posedge clk_in);
        #1;

        // Load under reset so the fetcher starts on known contents
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = $random(seed);
            data_access(addr_t'(i * 4), 1'b1, shadow[i], 1'b0, rd_word);
        end
        @(negedge clk_in);
        check_bit("reset_inst_valid", 1'b0, inst_valid);
        check_bit("reset_dresp_valid", 1'b0, dresp_valid);
        check_bit("reset_timer_irq", 1'b0, timer_irq);
        @(posedge clk_in);
        #1 reset = 1'b0;
        mon_en = 1'b1;

        for (int i = 0; i < NUM_READS; i++) begin
            rnd_word = $random(seed);
            data_access({rnd_word[9:2], 2'b00}, 1'b0, '0, 1'b1, rd_word);
            check_word("readback", shadow[rnd_word[9:2]], rd_word);
        end

        inst_ready = 1'b1;
        wait_pops(SEQ_POPS);

        rnd_word = $random(seed);
        send_redirect({rnd_word[6:0], 2'b00});
        inst_ready = 1'b1;
        wait_pops(REDIR_POPS);

        // Back to the start so the stream stays inside memory
        send_redirect(RESET_PC);
        for (int i = 0; i < NUM_READS; i++) begin
            rnd_word = $random(seed);
            read_addr[i] = {rnd_word[9:2], 2'b00};
        end
        pops_before = pop_count;
        fork
            begin
                for (int i = 0; i < NUM_READS; i++) begin
                    data_access(read_addr[i], 1'b0, '0, 1'b1, rd_word);
                    check_word("contention_read", shadow[read_addr[i][9:2]], rd_word);
                    repeat (read_addr[i][3:2]) begin    // Idle gap lets a fetch slip in
                        @(posedge clk_in);
                        #1;
                    end
                end
            end
            begin
                repeat (BP_CYCLES) begin
                    rnd_word   = $random(seed);
                    inst_ready = rnd_word[0];
                    @(posedge clk_in);
                    #1;
                end
            end
        join
        check_bit("contention_pops", 1'b1, pop_count > pops_before);

        inst_ready = 1'b0;
        check_bit("irq_idle", 1'b0, timer_irq);
        data_access(timer_addr(TSEL_CYCLE_LO), 1'b0, '0, 1'b1, val_a);
        repeat (TMR_GAP) @(posedge clk_in);
        #1;
        data_access(timer_addr(TSEL_CYCLE_LO), 1'b0, '0, 1'b1, val_b);
        check_bit("cycle_delta", 1'b1, (val_b - val_a) >= word_t'(TMR_GAP));

        data_access(timer_addr(TSEL_MTIME_LO), 1'b0, '0, 1'b1, val_a);
        repeat (4) begin
            repeat (TMR_GAP) @(posedge clk_in);
            #1;
            data_access(timer_addr(TSEL_MTIME_LO), 1'b0, '0, 1'b1, val_b);
            check_bit("mtime_monotonic", 1'b1, val_b >= val_a);
            val_a = val_b;
        end

        data_access(timer_addr(TSEL_CMP_LO), 1'b1, '0, 1'b1, rd_word);
        data_access(timer_addr(TSEL_CMP_HI), 1'b1, '0, 1'b1, rd_word);
        check_bit("irq_cmp_zero", 1'b1, timer_irq);
        data_access(timer_addr(TSEL_CMP_LO), 1'b1, '1, 1'b1, rd_word);
        data_access(timer_addr(TSEL_CMP_HI), 1'b1, '1, 1'b1, rd_word);
        check_bit("irq_cmp_ones", 1'b0, timer_irq);

        $display("Checks: %0d, errors: %0d, pops: %0d", check_count, err_count, pop_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
soc_pkg.sv
soc_timer.sv
soc_memory.sv
mem_bus_cntr.sv
inst_fetcher.sv
inst_queue.sv
soc_top.sv
tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_mem_timer

sources:
  - soc_pkg.sv
  - soc_timer.sv
  - soc_memory.sv
  - mem_bus_cntr.sv
  - inst_fetcher.sv
  - inst_queue.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc_top.sv
